/* list.f */
yuv_pkg.sv
rgb2yuv.sv
chroma_subsample.sv
yuv_pipe.sv
tb_yuv_pipe.sv

/* Makefile */
# Verilator build, run and lint for the YUYV colour pipe

VERILATOR ?= verilator
TOP       ?= tb_yuv_pipe
LINT_TOP  ?= yuv_pipe
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= TESTBENCH PASSED

SIM  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	if echo "$$out" | grep -q "$(PASS_MSG)"; then exit 0; else exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tb_yuv_pipe.sv */
// Testbench for yuv_pipe with stimulus table, colour reference model, random hold and timeout
`timescale 1ns/10ps

module tb_yuv_pipe;

    localparam int RESET_CYCLES = 16;
    localparam int HALF_PERIOD  = 4;            // 8 ns clock
    localparam int LEAD_IDLE    = 3;            // Beats before the frame opens
    localparam int TAIL_IDLE    = 6;            // Drain beats after the last line

    // One table row with the expected pixel from the model
    typedef struct packed {
        yuv_pkg::rgb_pixel_t rgb;
        logic                eol;               // Last pixel of its line
        yuv_pkg::yuv_pixel_t exp;
    } row_t;

    // What the DUT sees on one unheld cycle
    typedef struct packed {
        yuv_pkg::rgb_pixel_t rgb;
        logic                valid;
        yuv_pkg::vid_sync_t  sync;
        logic                closes;            // Odd pixel of a pair
    } beat_t;

    logic                clk;
    logic                resetn;
    yuv_pkg::rgb_pixel_t rgb;
    logic                rgb_valid;
    yuv_pkg::vid_sync_t  sync_in;
    logic                yuyv_hold;
    logic                rgb_hold;
    yuv_pkg::yuyv_word_t yuyv;
    logic                yuyv_valid;
    yuv_pkg::vid_sync_t  sync_out;

    row_t                rows[$];               // Stimulus table
    beat_t               beats[$];              // Table expanded into input cycles
    yuv_pkg::yuyv_word_t exp_words[$];          // Words still to come in order
    logic [31:0]         lfsr_state;
    int                  cycle_count;
    int                  cycle_limit;
    int                  word_count;

    yuv_pipe dut (
        .clk        (clk),
        .resetn     (resetn),
        .rgb        (rgb),
        .rgb_valid  (rgb_valid),
        .sync_in    (sync_in),
        .yuyv_hold  (yuyv_hold),
        .rgb_hold   (rgb_hold),
        .yuyv       (yuyv),
        .yuyv_valid (yuyv_valid),
        .sync_out   (sync_out)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Stop on the first error
    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            fail_now($sformatf("[FAIL] %0t: %s, got %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    // Hung run guard
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            fail_now($sformatf("Timeout: run still busy after %0d cycles", cycle_count));
        end
    end

    // Galois LFSR with taps at 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic take_bit();
        lfsr_state = lfsr_next(lfsr_state);     // One step per bit
        return lfsr_state[0];
    endfunction

    function automatic logic [7:0] take_byte();
        logic [7:0] v;
        for (int i = 0; i < 8; i++) begin
            v[i] = take_bit();
        end
        return v;
    endfunction

    function automatic logic next_hold();
        logic a;
        logic b;
        a = take_bit();
        b = take_bit();
        return a & b;                           // Held about one cycle in four
    endfunction

    function automatic logic [7:0] clamp_byte(input int v);
        logic [7:0] res;
        if (v < 0) res = 8'd0;
        else if (v > 255) res = 8'd255;
        else res = 8'(v);
        return res;
    endfunction

    // Integer BT.601 full range with rounding at each rescale
    function automatic yuv_pkg::yuv_pixel_t model_pixel(input yuv_pkg::rgb_pixel_t p);
        int                  ksum;
        int                  u;
        int                  v;
        int                  c_bias;
        yuv_pkg::yuv_pixel_t res;
        ksum = int'(yuv_pkg::KY_R) * int'(p.r) + int'(yuv_pkg::KY_G) * int'(p.g)
             + int'(yuv_pkg::KY_B) * int'(p.b);             // Y at scale 2^MW
        u = (int'(p.b) << yuv_pkg::MW) - ksum;
        v = (int'(p.r) << yuv_pkg::MW) - ksum;
        c_bias = (int'(yuv_pkg::C_OFFSET) << (2 * yuv_pkg::MW)) + (1 << (2 * yuv_pkg::MW - 1));
        res.y  = clamp_byte((ksum + (1 << (yuv_pkg::MW - 1))) >>> yuv_pkg::MW);
        res.cb = clamp_byte((u * int'(yuv_pkg::K_CB) + c_bias) >>> (2 * yuv_pkg::MW));
        res.cr = clamp_byte((v * int'(yuv_pkg::K_CR) + c_bias) >>> (2 * yuv_pkg::MW));
        return res;
    endfunction

    // Two pixels into one word with chroma rounded up
    function automatic yuv_pkg::yuyv_word_t pack_pair(input yuv_pkg::yuv_pixel_t a,
                                                      input yuv_pkg::yuv_pixel_t b);
        yuv_pkg::yuyv_word_t w;
        w.y0 = a.y;
        w.y1 = b.y;
        w.cb = 8'((int'(a.cb) + int'(b.cb) + 1) / 2);
        w.cr = 8'((int'(a.cr) + int'(b.cr) + 1) / 2);
        return w;
    endfunction

    task automatic add_row(input logic [7:0] r, input logic [7:0] g, input logic [7:0] b,
                           input logic eol);
        row_t row;
        row.rgb.r = r;
        row.rgb.g = g;
        row.rgb.b = b;
        row.eol   = eol;
        row.exp   = model_pixel(row.rgb);
        rows.push_back(row);
    endtask

    // Same colour twice so the word shows the plain conversion
    task automatic add_twin(input logic [7:0] r, input logic [7:0] g, input logic [7:0] b,
                            input logic eol);
        add_row(r, g, b, 1'b0);
        add_row(r, g, b, eol);
    endtask

    task automatic add_random_row(input logic eol);
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        r = take_byte();
        g = take_byte();
        b = take_byte();
        add_row(r, g, b, eol);
    endtask

    task automatic build_table();
        add_twin(8'd0, 8'd0, 8'd0, 1'b0);           // Black
        add_twin(8'd255, 8'd255, 8'd255, 1'b0);     // White
        add_twin(8'd128, 8'd128, 8'd128, 1'b0);     // Greys give chroma 128
        add_twin(8'd77, 8'd77, 8'd77, 1'b1);
        add_twin(8'd255, 8'd0, 8'd0, 1'b0);         // Primaries drive chroma to the rails
        add_twin(8'd0, 8'd255, 8'd0, 1'b0);
        add_twin(8'd0, 8'd0, 8'd255, 1'b1);
        add_twin(8'd0, 8'd255, 8'd255, 1'b0);       // Secondaries
        add_twin(8'd255, 8'd0, 8'd255, 1'b0);
        add_twin(8'd255, 8'd255, 8'd0, 1'b0);
        add_row(8'd255, 8'd128, 8'd0, 1'b1);        // Odd line whose pixel is dropped
        add_row(8'd255, 8'd0, 8'd0, 1'b0);          // Differing pairs
        add_row(8'd0, 8'd0, 8'd255, 1'b0);
        add_row(8'd255, 8'd255, 8'd255, 1'b0);
        add_row(8'd0, 8'd0, 8'd0, 1'b0);
        add_row(8'd0, 8'd255, 8'd0, 1'b0);
        add_row(8'd255, 8'd0, 8'd255, 1'b0);
        add_row(8'd200, 8'd30, 8'd90, 1'b0);
        add_row(8'd10, 8'd220, 8'd60, 1'b1);
        for (int i = 0; i < 16; i++) begin
            add_random_row(i == 15);
        end
        for (int i = 0; i < 5; i++) begin
            add_random_row(i == 4);                 // Odd random line
        end
        add_row(8'd200, 8'd200, 8'd200, 1'b1);      // Lone pixel that must not pair across lines
    endtask

    // Lines with a two cycle gap and expected words from the table
    task automatic build_beats();
        beat_t               bt;
        logic                odd;
        yuv_pkg::yuv_pixel_t pending;
        odd     = 1'b0;
        pending = '0;
        bt      = '0;
        repeat (LEAD_IDLE) beats.push_back(bt);
        bt.sync.frame_valid = 1'b1;
        beats.push_back(bt);                        // Frame opens ahead of the first line
        foreach (rows[i]) begin
            bt                  = '0;
            bt.rgb              = rows[i].rgb;
            bt.valid            = 1'b1;
            bt.sync.frame_valid = 1'b1;
            bt.sync.line_valid  = 1'b1;
            bt.closes           = odd;
            if (odd) begin
                exp_words.push_back(pack_pair(pending, rows[i].exp));
            end else begin
                pending = rows[i].exp;
            end
            odd = ~odd;
            beats.push_back(bt);
            if (rows[i].eol) begin
                odd                 = 1'b0;         // Parity restarts with the next line
                bt                  = '0;
                bt.sync.frame_valid = 1'b1;
                repeat (2) beats.push_back(bt);
            end
        end
        bt = '0;
        repeat (TAIL_IDLE) beats.push_back(bt);
    endtask

    task automatic drive_beat(input beat_t bt);
        rgb       = bt.rgb;
        rgb_valid = bt.valid;
        sync_in   = bt.sync;
    endtask

    initial begin : stimulus
        yuv_pkg::vid_sync_t  sync_hist [4];         // Sync of the last four unheld cycles
        logic                close_hist [4];
        yuv_pkg::yuyv_word_t last_yuyv;
        logic                last_valid;
        yuv_pkg::vid_sync_t  last_sync;
        logic                cur_hold;
        int                  idx;
        resetn      = 1'b0;
        rgb         = '0;
        rgb_valid   = 1'b1;                         // Live pixels and sync through reset
        sync_in     = '1;
        yuyv_hold   = 1'b0;
        lfsr_state  = 32'h2377_455b;
        cycle_count = 0;
        cycle_limit = 0;
        word_count  = 0;
        build_table();
        build_beats();
        cycle_limit = 4 * rows.size() + RESET_CYCLES + 100;
        for (int i = 0; i < 4; i++) begin
            sync_hist[i]  = '0;
            close_hist[i] = 1'b0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        check_equal(32'(yuyv_valid), 32'd0, "yuyv_valid after reset");
        check_equal(32'(sync_out), 32'd0, "sync_out after reset");
        last_yuyv  = yuyv;
        last_valid = yuyv_valid;
        last_sync  = sync_out;

        idx       = 0;
        cur_hold  = next_hold();
        yuyv_hold = cur_hold;
        drive_beat(beats[idx]);
        while (idx < beats.size()) begin
            @(negedge clk);                         // Outputs settled after the rising edge
            check_equal(32'(rgb_hold), 32'(yuyv_hold), "rgb_hold follows yuyv_hold");
            if (cur_hold) begin
                check_equal(yuyv, last_yuyv, "yuyv changed under hold");
                check_equal(32'(yuyv_valid), 32'(last_valid), "yuyv_valid changed under hold");
                check_equal(32'(sync_out), 32'(last_sync), "sync_out changed under hold");
            end else begin
                for (int i = 3; i > 0; i--) begin
                    sync_hist[i]  = sync_hist[i-1];
                    close_hist[i] = close_hist[i-1];
                end
                sync_hist[0]  = beats[idx].sync;
                close_hist[0] = beats[idx].closes;
                check_equal(32'(sync_out), 32'(sync_hist[3]), "sync_out vs sync_in 4 back");
                check_equal(32'(yuyv_valid), 32'(close_hist[3]), "yuyv_valid vs odd pixel");
                if (yuyv_valid) begin
                    if (exp_words.size() == 0) begin
                        fail_now("DUT produced a word that the stimulus does not explain");
                    end
                    check_equal(yuyv, exp_words.pop_front(), $sformatf("word %0d", word_count));
                    word_count++;
                end
                idx++;                              // Beat taken by the DUT
            end
            last_yuyv  = yuyv;
            last_valid = yuyv_valid;
            last_sync  = sync_out;
            if (idx < beats.size()) begin
                cur_hold  = next_hold();
                yuyv_hold = cur_hold;
                drive_beat(beats[idx]);             // Same pixel again if it was held
            end
        end
        yuyv_hold = 1'b0;

        if (exp_words.size() != 0) begin
            fail_now($sformatf("%0d expected words never came out", exp_words.size()));
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* yuv_pipe.sv */
// Colour front end top level chaining the RGB converter and the 4:2:2 decimator
`timescale 1ns/10ps

module yuv_pipe (
    input  logic                clk,
    input  logic                resetn,
    input  yuv_pkg::rgb_pixel_t rgb,
    input  logic                rgb_valid,
    input  yuv_pkg::vid_sync_t  sync_in,
    input  logic                yuyv_hold,  // Stall from the sink
    output logic                rgb_hold,   // Stall to the source
    output yuv_pkg::yuyv_word_t yuyv,
    output logic                yuyv_valid,
    output yuv_pkg::vid_sync_t  sync_out
);

    // Converter to decimator link
    yuv_pkg::yuv_pixel_t yuv;
    logic                yuv_valid;
    yuv_pkg::vid_sync_t  yuv_sync;

    // One hold level for every stage, handed straight back to the source
    assign rgb_hold = yuyv_hold;

    // Three cycles, RGB in to clamped Y Cb Cr out
    rgb2yuv u_rgb2yuv (
        .clk        (clk),
        .resetn     (resetn),
        .rgb        (rgb),
        .rgb_valid  (rgb_valid),
        .sync_in    (sync_in),
        .hold       (yuyv_hold),
        .yuv        (yuv),
        .yuv_valid  (yuv_valid),
        .sync_out   (yuv_sync)
    );

    // One more cycle, pixel pairs to YUYV words
    chroma_subsample u_chroma_subsample (
        .clk        (clk),
        .resetn     (resetn),
        .yuv        (yuv),
        .yuv_valid  (yuv_valid),
        .sync_in    (yuv_sync),
        .hold       (yuyv_hold),
        .yuyv       (yuyv),
        .yuyv_valid (yuyv_valid),
        .sync_out   (sync_out)
    );

endmodule

/* chroma_subsample.sv */
// Horizontal 4:2:2 chroma decimator that pairs pixels into averaged YUYV words
`timescale 1ns/10ps

module chroma_subsample (
    input  logic                clk,
    input  logic                resetn,
    input  yuv_pkg::yuv_pixel_t yuv,
    input  logic                yuv_valid,
    input  yuv_pkg::vid_sync_t  sync_in,
    input  logic                hold,       // Downstream stall, freezes every register
    output yuv_pkg::yuyv_word_t yuyv,
    output logic                yuyv_valid,
    output yuv_pkg::vid_sync_t  sync_out
);

    logic                   odd_pix;        // High when the next pixel closes a pair
    yuv_pkg::yuv_pixel_t    even_pix;       // First pixel of the open pair
    logic                   pix_in_line;    // Valid pixel inside an active line
    logic                   take_even;
    logic                   pair_done;
    logic [yuv_pkg::DW:0]   cb_sum;         // One bit wider for the carry
    logic [yuv_pkg::DW:0]   cr_sum;
    yuv_pkg::yuyv_word_t    word;

    always_comb begin
        pix_in_line = yuv_valid & sync_in.line_valid;
        take_even   = pix_in_line & ~odd_pix;
        pair_done   = pix_in_line & odd_pix;
    end

    // Pair parity restarts at every line, so a trailing pixel never
    // pairs with the start of the next line
    always_ff @(posedge clk) begin
        if (!resetn) begin
            odd_pix <= 1'b0;
        end else if (!hold) begin
            if (!sync_in.line_valid)
                odd_pix <= 1'b0;                // Gap between lines
            else if (yuv_valid)
                odd_pix <= ~odd_pix;
        end
    end

    // Hold the even pixel until its partner arrives
    always_ff @(posedge clk) begin
        if (take_even && !hold) begin
            even_pix <= yuv;
        end
    end

    // Averages round up, (a + b + 1) / 2
    always_comb begin
        cb_sum  = {1'b0, even_pix.cb} + {1'b0, yuv.cb} + 1'b1;
        cr_sum  = {1'b0, even_pix.cr} + {1'b0, yuv.cr} + 1'b1;
        word.y0 = even_pix.y;                   // Earlier pixel first
        word.cb = cb_sum[yuv_pkg::DW:1];
        word.y1 = yuv.y;
        word.cr = cr_sum[yuv_pkg::DW:1];
    end

    // Output word, payload only
    always_ff @(posedge clk) begin
        if (pair_done && !hold) begin
            yuyv <= word;
        end
    end

    // One word per pair, sync one cycle behind the input like the data
    always_ff @(posedge clk) begin
        if (!resetn) begin
            yuyv_valid <= 1'b0;
            sync_out   <= '0;
        end else if (!hold) begin
            yuyv_valid <= pair_done;
            sync_out   <= sync_in;
        end
    end

endmodule

/* rgb2yuv.sv */
// Three-stage RGB to Y Cb Cr colour space converter with rounding and clamping
`timescale 1ns/10ps

module rgb2yuv (
    input  logic                clk,
    input  logic                resetn,
    input  yuv_pkg::rgb_pixel_t rgb,
    input  logic                rgb_valid,
    input  yuv_pkg::vid_sync_t  sync_in,
    input  logic                hold,       // Freezes all three stages
    output yuv_pkg::yuv_pixel_t yuv,
    output logic                yuv_valid,
    output yuv_pkg::vid_sync_t  sync_out
);

    // Sample times weight built from shifted copies for each set bit of k
    function automatic logic [yuv_pkg::YW+yuv_pkg::MW-1:0] mul_y(
        input logic [yuv_pkg::DW-1:0] s,
        input logic [yuv_pkg::MW-1:0] k
    );
        logic [yuv_pkg::YW+yuv_pkg::MW-1:0] ext;
        logic [yuv_pkg::YW+yuv_pkg::MW-1:0] acc;
        ext = {{(yuv_pkg::YW+yuv_pkg::MW-yuv_pkg::DW){1'b0}}, s};
        acc = '0;
        for (int i = 0; i < yuv_pkg::MW; i++) begin
            if (k[i]) acc = acc + (ext << i);
        end
        return acc;
    endfunction

    // Signed colour difference times chroma gain by the same shift-and-add scheme
    function automatic logic signed [yuv_pkg::YW+2*yuv_pkg::MW-1:0] mul_c(
        input logic signed [yuv_pkg::YW+yuv_pkg::MW-1:0] d,
        input logic        [yuv_pkg::MW-1:0]             k
    );
        logic signed [yuv_pkg::YW+2*yuv_pkg::MW-1:0] ext;
        logic signed [yuv_pkg::YW+2*yuv_pkg::MW-1:0] acc;
        ext = d;                                // Sign extends
        acc = '0;
        for (int i = 0; i < yuv_pkg::MW; i++) begin
            if (k[i]) acc = acc + (ext <<< i);
        end
        return acc;
    endfunction

    // Saturate a signed intermediate to 0..255
    function automatic logic [yuv_pkg::DW-1:0] clamp(input logic signed [yuv_pkg::YW-1:0] v);
        logic [yuv_pkg::DW-1:0] res;
        if (v[yuv_pkg::YW-1]) res = '0;                         // Negative
        else if (v[yuv_pkg::YW-2]) res = '1;                    // Above 255
        else res = v[yuv_pkg::DW-1:0];
        return res;
    endfunction

    // Stage 0 registers hold the weighted products plus raw R and B
    logic [yuv_pkg::YW+yuv_pkg::MW-1:0] kr0, kg0, kb0;
    logic [yuv_pkg::DW-1:0]             r0, b0;
    logic                               valid0;
    yuv_pkg::vid_sync_t                 sync0;

    always_ff @(posedge clk) begin
        if (rgb_valid && !hold) begin
            kr0 <= mul_y(rgb.r, yuv_pkg::KY_R);
            kg0 <= mul_y(rgb.g, yuv_pkg::KY_G);
            kb0 <= mul_y(rgb.b, yuv_pkg::KY_B);
            r0  <= rgb.r;
            b0  <= rgb.b;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid0 <= 1'b0;
            sync0  <= '0;
        end else if (!hold) begin
            valid0 <= rgb_valid;
            sync0  <= sync_in;
        end
    end

    // Stage 1 luma sum and the B-Y and R-Y differences still scaled by 2^MW
    logic        [yuv_pkg::YW+yuv_pkg::MW-1:0] k_sum;     // At most 256*255
    logic        [yuv_pkg::YW+yuv_pkg::MW-1:0] y_rnd;
    logic signed [yuv_pkg::YW+yuv_pkg::MW-1:0] u_s1, v_s1;
    logic        [yuv_pkg::YW-1:0]             y1;
    logic signed [yuv_pkg::YW+yuv_pkg::MW-1:0] u1, v1;
    logic                                      valid1;
    yuv_pkg::vid_sync_t                        sync1;

    always_comb begin
        k_sum = kr0 + kg0 + kb0;
        y_rnd = k_sum + {{yuv_pkg::YW{1'b0}}, 1'b1, {(yuv_pkg::MW-1){1'b0}}}; // Plus half LSB
        // Sample moved up by MW to match the product scale
        u_s1 = $signed({{(yuv_pkg::YW-yuv_pkg::DW){1'b0}}, b0, {yuv_pkg::MW{1'b0}}})
             - $signed(k_sum);
        v_s1 = $signed({{(yuv_pkg::YW-yuv_pkg::DW){1'b0}}, r0, {yuv_pkg::MW{1'b0}}})
             - $signed(k_sum);
    end

    always_ff @(posedge clk) begin
        if (valid0 && !hold) begin
            y1 <= y_rnd[yuv_pkg::YW+yuv_pkg::MW-1:yuv_pkg::MW];     // Rounded Y
            u1 <= u_s1;                                             // Range about +/-226 * 2^MW
            v1 <= v_s1;                                             // Range about +/-179 * 2^MW
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid1 <= 1'b0;
            sync1  <= '0;
        end else if (!hold) begin
            valid1 <= valid0;
            sync1  <= sync0;
        end
    end

    // Stage 2 applies chroma gain, offset and rounding at scale 2^(2*MW)
    logic signed [yuv_pkg::YW+2*yuv_pkg::MW-1:0] c_base;   // Offset plus rounding half
    logic signed [yuv_pkg::YW+2*yuv_pkg::MW-1:0] cb_acc, cr_acc;
    logic signed [yuv_pkg::YW-1:0]               cb2, cr2;
    logic        [yuv_pkg::DW-1:0]               y2;

    always_comb begin
        c_base = $signed({{(yuv_pkg::YW-yuv_pkg::DW){1'b0}}, yuv_pkg::C_OFFSET,
                          {(2*yuv_pkg::MW){1'b0}}})
               + $signed({{yuv_pkg::YW{1'b0}}, 1'b1, {(2*yuv_pkg::MW-1){1'b0}}});
        cb_acc = mul_c(u1, yuv_pkg::K_CB) + c_base;
        cr_acc = mul_c(v1, yuv_pkg::K_CR) + c_base;
        // Top bits give floor division and the half above turns it into round to nearest
        cb2 = $signed(cb_acc[yuv_pkg::YW+2*yuv_pkg::MW-1:2*yuv_pkg::MW]);
        cr2 = $signed(cr_acc[yuv_pkg::YW+2*yuv_pkg::MW-1:2*yuv_pkg::MW]);
        y2  = (|y1[yuv_pkg::YW-1:yuv_pkg::DW]) ? '1 : y1[yuv_pkg::DW-1:0]; // Y is never negative
    end

    always_ff @(posedge clk) begin
        if (valid1 && !hold) begin
            yuv.y  <= y2;
            yuv.cb <= clamp(cb2);                   // Pure blue drives Cb to the top rail
            yuv.cr <= clamp(cr2);                   // Pure red drives Cr to the top rail
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            yuv_valid <= 1'b0;
            sync_out  <= '0;
        end else if (!hold) begin
            yuv_valid <= valid1;
            sync_out  <= sync1;
        end
    end

endmodule

/* yuv_pkg.sv */
// Data widths, BT.601 colour constants and the pixel, sync and YUYV word types
package yuv_pkg;

    localparam int DW = 8;                      // One colour sample
    localparam int MW = 8;                      // Fraction bits of the constant multipliers
    localparam int YW = DW + 2;                 // Overflow bit above 255 plus a sign bit

    // Y weights, 0.299 / 0.587 / 0.114 scaled by 256
    localparam logic [MW-1:0] KY_R = 8'd77;     // 0100_1101
    localparam logic [MW-1:0] KY_G = 8'd150;    // 1001_0110
    localparam logic [MW-1:0] KY_B = 8'd29;     // 0001_1101

    // Chroma gains 1/1.772 and 1/1.402, Cr tuned by one LSB
    localparam logic [MW-1:0] K_CB = 8'd144;    // 1001_0000
    localparam logic [MW-1:0] K_CR = 8'd182;    // 1011_0110

    localparam logic [DW-1:0] C_OFFSET = 8'd128; // Chroma zero level

    // One RGB sample triple, r in the top byte
    typedef struct packed {
        logic [DW-1:0] r;
        logic [DW-1:0] g;
        logic [DW-1:0] b;
    } rgb_pixel_t;

    // One converted pixel
    typedef struct packed {
        logic [DW-1:0] y;
        logic [DW-1:0] cb;
        logic [DW-1:0] cr;
    } yuv_pixel_t;

    // Frame and line valid levels, delayed in step with the data
    typedef struct packed {
        logic frame_valid;
        logic line_valid;
    } vid_sync_t;

    // Two pixels sharing one chroma pair, YUYV byte order from the top
    typedef struct packed {
        logic [DW-1:0] y0;
        logic [DW-1:0] cb;
        logic [DW-1:0] y1;
        logic [DW-1:0] cr;
    } yuyv_word_t;

endpackage
